/* include/rename_config.svh */
// Register counts and graduation-list depth for the rename back end, included by package and RTL

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Architectural register file as seen by software
`define RENAME_NUM_ARCH_REGS 32

// Physical registers behind the rename table
// Registers above the architectural count start out free
`define RENAME_NUM_PHYS_REGS 64

// In-flight instructions between rename and commit
`define RENAME_GL_DEPTH 16

`endif

/* logic/rename_pkg.sv */
// Index types shared by the rename RTL and its testbench, compiled ahead of every module

`default_nettype none

`include "rename_config.svh"

package rename_pkg;

    ////////////////////
    // Index widths
    ////////////////////

    // Derived from the config header so that one edit resizes everything
    localparam int unsigned ARCH_REG_W = $clog2(`RENAME_NUM_ARCH_REGS);
    localparam int unsigned PHYS_REG_W = $clog2(`RENAME_NUM_PHYS_REGS);
    localparam int unsigned GL_INDEX_W = $clog2(`RENAME_GL_DEPTH);

    ////////////////////
    // Index types
    ////////////////////

    // Architectural register number, as decoded from the instruction
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // Physical register number, produced by the free list
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;

    // Slot in the graduation list, carried by writeback
    typedef logic [GL_INDEX_W-1:0] gl_index_t;

endpackage

`default_nettype wire

/* logic/free_list.sv */
// Circular queue of free physical registers, popped by rename and refilled by commit

`timescale 1ns/100ps
`default_nettype none

`include "rename_config.svh"

module free_list (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,
    input  wire logic                 pop_i,
    input  wire logic                 push_i,
    input  wire rename_pkg::phys_reg_t push_reg_i,
    output rename_pkg::phys_reg_t     head_reg_o
);

    import rename_pkg::*;

    // Registers not covered by the identity mapping at reset
    localparam int unsigned NUM_FREE = `RENAME_NUM_PHYS_REGS - `RENAME_NUM_ARCH_REGS;
    localparam int unsigned PTR_W    = $clog2(NUM_FREE);

    phys_reg_t              fifo_q [NUM_FREE];
    logic [PTR_W-1:0]       head_q;
    logic [PTR_W-1:0]       tail_q;

    // Next register handed to rename
    assign head_reg_o = fifo_q[head_q];

    // Pointers
    // The queue starts full, so head and tail coincide after reset
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // Storage
    // Reset loads the upper physical registers in ascending order
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_FREE; i++) begin
                fifo_q[i] <= phys_reg_t'(`RENAME_NUM_ARCH_REGS + i);
            end
        end else if (push_i) begin
            fifo_q[tail_q] <= push_reg_i;
        end
    end

endmodule

`default_nettype wire

/* logic/rename_table.sv */
// Architectural to physical register map, read for sources and old destination, written at rename

`timescale 1ns/100ps
`default_nettype none

`include "rename_config.svh"

module rename_table (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire rename_pkg::arch_reg_t rs1_i,
    input  wire rename_pkg::arch_reg_t rs2_i,
    input  wire rename_pkg::arch_reg_t rd_i,
    input  wire logic                  write_i,
    input  wire rename_pkg::phys_reg_t new_prd_i,
    output rename_pkg::phys_reg_t      prs1_o,
    output rename_pkg::phys_reg_t      prs2_o,
    output rename_pkg::phys_reg_t      old_prd_o
);

    import rename_pkg::*;

    localparam int unsigned NUM_ARCH = `RENAME_NUM_ARCH_REGS;

    // One physical register per architectural one
    phys_reg_t map_q [NUM_ARCH];

    ////////////////////
    // Lookups
    ////////////////////

    // Reads see the map before this cycle's write, so rs equal to rd
    // still gets the previous mapping
    assign prs1_o    = map_q[rs1_i];
    assign prs2_o    = map_q[rs2_i];
    assign old_prd_o = map_q[rd_i];

    ////////////////////
    // Update
    ////////////////////

    // Identity mapping out of reset
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
        end else if (write_i) begin
            map_q[rd_i] <= new_prd_i;
        end
    end

endmodule

`default_nettype wire

/* logic/graduation_list.sv */
// In-order list of renamed instructions, completed out of order by writeback and retired in order

`timescale 1ns/100ps
`default_nettype none

`include "rename_config.svh"

module graduation_list (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    // Dispatch side
    input  wire logic                  push_i,
    input  wire rename_pkg::arch_reg_t push_rd_i,
    input  wire logic                  push_we_i,
    input  wire rename_pkg::phys_reg_t push_prd_i,
    input  wire rename_pkg::phys_reg_t push_old_prd_i,
    // Completion marks
    input  wire logic                  wb_valid_i,
    input  wire rename_pkg::gl_index_t wb_index_i,
    // Retirement
    input  wire logic                  commit_ready_i,
    output rename_pkg::gl_index_t      push_index_o,
    output logic                       full_o,
    output logic                       commit_valid_o,
    output logic                       commit_we_o,
    output rename_pkg::arch_reg_t      commit_rd_o,
    output rename_pkg::phys_reg_t      commit_prd_o,
    output rename_pkg::phys_reg_t      commit_old_prd_o
);

    import rename_pkg::*;

    localparam int unsigned DEPTH = `RENAME_GL_DEPTH;
    localparam int unsigned CNT_W = $clog2(DEPTH) + 1;
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    // Entry payload
    arch_reg_t          rd_q      [DEPTH];
    logic               we_q      [DEPTH];
    phys_reg_t          prd_q     [DEPTH];
    phys_reg_t          old_prd_q [DEPTH];

    // Control state
    logic [DEPTH-1:0]   done_q;
    gl_index_t          head_q;
    gl_index_t          tail_q;
    logic [CNT_W-1:0]   count_q;

    logic               pop;

    ////////////////////
    // Status
    ////////////////////

    assign full_o       = (count_q == FULL_COUNT);
    assign push_index_o = tail_q;

    // Head is retirable once it exists and has been written back
    assign commit_valid_o   = (count_q != '0) && done_q[head_q];
    assign commit_we_o      = we_q[head_q];
    assign commit_rd_o      = rd_q[head_q];
    assign commit_prd_o     = prd_q[head_q];
    assign commit_old_prd_o = old_prd_q[head_q];

    assign pop = commit_valid_o && commit_ready_i;

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Completion bits
    // A new entry starts pending, writeback never targets it in the same edge
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            done_q <= '0;
        end else begin
            if (push_i) begin
                done_q[tail_q] <= 1'b0;
            end
            if (wb_valid_i) begin
                done_q[wb_index_i] <= 1'b1;
            end
        end
    end

    // Payload written at the tail
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            rd_q[tail_q]      <= push_rd_i;
            we_q[tail_q]      <= push_we_i;
            prd_q[tail_q]     <= push_prd_i;
            old_prd_q[tail_q] <= push_old_prd_i;
        end
    end

endmodule

`default_nettype wire

/* logic/rename_unit.sv */
// Rename back end top, joining free list, rename table and graduation list behind dispatch and commit

`timescale 1ns/100ps
`default_nettype none

module rename_unit (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    // Dispatch
    input  wire logic                  in_valid_i,
    input  wire rename_pkg::arch_reg_t in_rs1_i,
    input  wire rename_pkg::arch_reg_t in_rs2_i,
    input  wire rename_pkg::arch_reg_t in_rd_i,
    input  wire logic                  in_we_i,
    output logic                       in_ready_o,
    // Renamed instruction
    output logic                       out_valid_o,
    output rename_pkg::phys_reg_t      out_prs1_o,
    output rename_pkg::phys_reg_t      out_prs2_o,
    output rename_pkg::phys_reg_t      out_prd_o,
    output rename_pkg::phys_reg_t      out_old_prd_o,
    output rename_pkg::gl_index_t      out_gl_index_o,
    // Writeback
    input  wire logic                  wb_valid_i,
    input  wire rename_pkg::gl_index_t wb_index_i,
    // Commit
    input  wire logic                  commit_ready_i,
    output logic                       commit_valid_o,
    output rename_pkg::arch_reg_t      commit_rd_o,
    output rename_pkg::phys_reg_t      commit_prd_o,
    output rename_pkg::phys_reg_t      commit_old_prd_o,
    output logic                       commit_we_o
);

    import rename_pkg::*;

    logic       gl_full;
    gl_index_t  gl_push_index;
    logic       accept;
    logic       writes_rd;
    logic       alloc;
    logic       free_push;

    phys_reg_t  fl_head;
    phys_reg_t  rt_prs1;
    phys_reg_t  rt_prs2;
    phys_reg_t  rt_old_prd;
    phys_reg_t  dst_prd;
    phys_reg_t  dst_old_prd;

    ////////////////////
    // Dispatch control
    ////////////////////

    assign in_ready_o = !gl_full;
    assign accept     = in_valid_i && in_ready_o;

    // x0 is never renamed
    assign writes_rd = in_we_i && (in_rd_i != '0);
    assign alloc     = accept && writes_rd;

    // Destination fields read as zero when nothing is allocated
    assign dst_prd     = writes_rd ? fl_head    : '0;
    assign dst_old_prd = writes_rd ? rt_old_prd : '0;

    // Old mapping goes back to the pool when its overwriter retires
    assign free_push = commit_valid_o && commit_ready_i && commit_we_o;

    free_list free_list_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .pop_i      (alloc),
        .push_i     (free_push),
        .push_reg_i (commit_old_prd_o),
        .head_reg_o (fl_head)
    );

    rename_table rename_table_inst (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rs1_i     (in_rs1_i),
        .rs2_i     (in_rs2_i),
        .rd_i      (in_rd_i),
        .write_i   (alloc),
        .new_prd_i (fl_head),
        .prs1_o    (rt_prs1),
        .prs2_o    (rt_prs2),
        .old_prd_o (rt_old_prd)
    );

    ////////////////////
    // Graduation list
    ////////////////////

    graduation_list graduation_list_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .push_i           (accept),
        .push_rd_i        (in_rd_i),
        .push_we_i        (writes_rd),
        .push_prd_i       (dst_prd),
        .push_old_prd_i   (dst_old_prd),
        .wb_valid_i       (wb_valid_i),
        .wb_index_i       (wb_index_i),
        .commit_ready_i   (commit_ready_i),
        .push_index_o     (gl_push_index),
        .full_o           (gl_full),
        .commit_valid_o   (commit_valid_o),
        .commit_we_o      (commit_we_o),
        .commit_rd_o      (commit_rd_o),
        .commit_prd_o     (commit_prd_o),
        .commit_old_prd_o (commit_old_prd_o)
    );

    ////////////////////
    // Output register
    ////////////////////

    // One-cycle valid pulse per accepted instruction
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= accept;
        end
    end

    // Renamed fields captured with the acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_prs1_o     <= rt_prs1;
            out_prs2_o     <= rt_prs2;
            out_prd_o      <= dst_prd;
            out_old_prd_o  <= dst_old_prd;
            out_gl_index_o <= gl_push_index;
        end
    end

endmodule

`default_nettype wire

/* test/rename_checker.sv */
// Scoreboard for the rename unit, instantiated by the testbench top to watch and check the DUT ports

`timescale 1ns/100ps
`default_nettype none

`include "rename_config.svh"

module rename_checker (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  in_valid_i,
    input  wire logic                  in_ready_i,
    input  wire logic                  in_we_i,
    input  wire rename_pkg::arch_reg_t in_rs1_i,
    input  wire rename_pkg::arch_reg_t in_rs2_i,
    input  wire rename_pkg::arch_reg_t in_rd_i,
    input  wire logic                  out_valid_i,
    input  wire rename_pkg::phys_reg_t out_prs1_i,
    input  wire rename_pkg::phys_reg_t out_prs2_i,
    input  wire rename_pkg::phys_reg_t out_prd_i,
    input  wire rename_pkg::phys_reg_t out_old_prd_i,
    input  wire rename_pkg::gl_index_t out_gl_index_i,
    input  wire logic                  wb_valid_i,
    input  wire rename_pkg::gl_index_t wb_index_i,
    input  wire logic                  commit_ready_i,
    input  wire logic                  commit_valid_i,
    input  wire logic                  commit_we_i,
    input  wire rename_pkg::arch_reg_t commit_rd_i,
    input  wire rename_pkg::phys_reg_t commit_prd_i,
    input  wire rename_pkg::phys_reg_t commit_old_prd_i,
    output int unsigned                error_count_o
);

    import rename_pkg::*;

    typedef struct packed {
        phys_reg_t prs1;
        phys_reg_t prs2;
        phys_reg_t prd;
        phys_reg_t old_prd;
        gl_index_t gl_index;
    } rename_rec_t;

    typedef struct packed {
        arch_reg_t rd;
        logic      we;
        phys_reg_t prd;
        phys_reg_t old_prd;
    } commit_rec_t;

    // Reference model of map, free pool and list occupancy
    phys_reg_t                   map_m [`RENAME_NUM_ARCH_REGS];
    phys_reg_t                   free_m [$];
    commit_rec_t                 commit_q [$];
    logic [`RENAME_GL_DEPTH-1:0] done_m = '0;
    gl_index_t                   head_m = '0;
    gl_index_t                   tail_m = '0;
    int unsigned                 count_m = 0;
    rename_rec_t                 exp_out;
    commit_rec_t                 retired;
    logic                        out_pending = 1'b0;
    logic                        exp_commit;
    logic                        alloc_m;
    int unsigned                 checks = 0;
    int unsigned                 errors = 0;
    int unsigned                 test_errors = 0;
    int unsigned                 tests = 0;
    int unsigned                 failed = 0;

    assign error_count_o = errors;

    // Identity map, registers above the architectural ones start free
    initial begin
        for (int i = 0; i < `RENAME_NUM_ARCH_REGS; i++) begin
            map_m[i] = phys_reg_t'(i);
        end
        for (int i = `RENAME_NUM_ARCH_REGS; i < `RENAME_NUM_PHYS_REGS; i++) begin
            free_m.push_back(phys_reg_t'(i));
        end
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Sources read the map before this instruction's own write
    function automatic rename_rec_t rename_ref(arch_reg_t rs1, arch_reg_t rs2, arch_reg_t rd,
                                               logic we);
        rename_rec_t rec;
        rec.prs1     = map_m[rs1];
        rec.prs2     = map_m[rs2];
        rec.prd      = '0;
        rec.old_prd  = '0;
        rec.gl_index = tail_m;
        if (we && rd != '0) begin
            rec.prd     = free_m.pop_front();
            rec.old_prd = map_m[rd];
            map_m[rd]   = rec.prd;
        end
        return rec;
    endfunction

    ////////////////////
    // Compare
    ////////////////////

    // Falling edge, so DUT outputs have settled since the last rising edge
    always @(negedge clk_i) begin
        if (rstn_i) begin
            exp_commit = (count_m != 0) && done_m[head_m];
            check_value("out_valid_o", 32'(out_valid_i), 32'(out_pending));
            if (out_valid_i && out_pending) begin
                check_value("out_prs1_o", 32'(out_prs1_i), 32'(exp_out.prs1));
                check_value("out_prs2_o", 32'(out_prs2_i), 32'(exp_out.prs2));
                check_value("out_prd_o", 32'(out_prd_i), 32'(exp_out.prd));
                check_value("out_old_prd_o", 32'(out_old_prd_i), 32'(exp_out.old_prd));
                check_value("out_gl_index_o", 32'(out_gl_index_i), 32'(exp_out.gl_index));
            end
            check_value("in_ready_o", 32'(in_ready_i), 32'(count_m != `RENAME_GL_DEPTH));
            check_value("commit_valid_o", 32'(commit_valid_i), 32'(exp_commit));
            // Head fields also stay put while commit_ready_i is low
            if (exp_commit && commit_q.size() != 0) begin
                check_value("commit_rd_o", 32'(commit_rd_i), 32'(commit_q[0].rd));
                check_value("commit_we_o", 32'(commit_we_i), 32'(commit_q[0].we));
                check_value("commit_prd_o", 32'(commit_prd_i), 32'(commit_q[0].prd));
                check_value("commit_old_prd_o", 32'(commit_old_prd_i),
                            32'(commit_q[0].old_prd));
            end

            // Events that land on the coming rising edge
            out_pending = in_valid_i && in_ready_i;
            if (out_pending) begin
                alloc_m = in_we_i && (in_rd_i != '0);
                exp_out = rename_ref(in_rs1_i, in_rs2_i, in_rd_i, in_we_i);
                commit_q.push_back('{in_rd_i, alloc_m, exp_out.prd, exp_out.old_prd});
                done_m[tail_m] = 1'b0;
                tail_m++;
                count_m++;
            end
            if (wb_valid_i) begin
                done_m[wb_index_i] = 1'b1;
            end
            if (exp_commit && commit_ready_i && commit_q.size() != 0) begin
                retired = commit_q.pop_front();
                if (retired.we) begin
                    free_m.push_back(retired.old_prd);
                end
                head_m++;
                count_m--;
            end
        end
    end

    task automatic report_test(string name);
        tests++;
        if (test_errors == 0) begin
            $display("Test %0d (%s): clean", tests, name);
        end else begin
            failed++;
            $display("Test %0d (%s): %0d mismatches", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic report_summary();
        $display("Tests: %0d run, %0d failed; checks: %0d, mismatches: %0d",
                 tests, failed, checks, errors);
    endtask

endmodule

`default_nettype wire

/* test/tb_rename_unit.sv */
// Testbench top for the rename unit with clock, reset, random dispatch, writeback and commit stalls

`timescale 1ns/100ps
`default_nettype none

`include "rename_config.svh"

module tb_rename_unit;

    import rename_pkg::*;

    // Cycles any single wait may take
    localparam int unsigned TIMEOUT = 1000;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic        in_valid_i;
    logic        in_we_i;
    logic        in_ready_o;
    arch_reg_t   in_rs1_i, in_rs2_i, in_rd_i;
    logic        out_valid_o;
    phys_reg_t   out_prs1_o, out_prs2_o, out_prd_o, out_old_prd_o;
    gl_index_t   out_gl_index_o;
    logic        wb_valid_i;
    gl_index_t   wb_index_i;
    logic        commit_ready_i;
    logic        commit_valid_o;
    logic        commit_we_o;
    arch_reg_t   commit_rd_o;
    phys_reg_t   commit_prd_o, commit_old_prd_o;

    int unsigned error_count;
    logic        hung;
    logic        wb_enable;
    int unsigned ready_pct;
    int          inflight;
    int unsigned pick;
    gl_index_t   pending_wb [$];

    always #50 clk_i = ~clk_i;

    rename_unit DUT (.*);

    rename_checker scoreboard (
        .*,
        .in_ready_i       (in_ready_o),
        .out_valid_i      (out_valid_o),
        .out_prs1_i       (out_prs1_o),
        .out_prs2_i       (out_prs2_o),
        .out_prd_i        (out_prd_o),
        .out_old_prd_i    (out_old_prd_o),
        .out_gl_index_i   (out_gl_index_o),
        .commit_valid_i   (commit_valid_o),
        .commit_we_i      (commit_we_o),
        .commit_rd_i      (commit_rd_o),
        .commit_prd_i     (commit_prd_o),
        .commit_old_prd_i (commit_old_prd_o),
        .error_count_o    (error_count)
    );

    // Writeback of a random outstanding slot, random commit stalls
    always @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_i     <= 1'b0;
            wb_index_i     <= '0;
            commit_ready_i <= 1'b0;
            inflight       <= 0;
        end else begin
            if (out_valid_o) begin
                pending_wb.push_back(out_gl_index_o);
            end
            wb_valid_i <= 1'b0;
            if (wb_enable && pending_wb.size() != 0 && $urandom_range(2) == 0) begin
                pick = $urandom_range(pending_wb.size() - 1);
                wb_valid_i <= 1'b1;
                wb_index_i <= pending_wb[pick];
                pending_wb.delete(pick);
            end
            commit_ready_i <= ($urandom_range(99) < ready_pct);
            inflight <= inflight + int'(in_valid_i && in_ready_o)
                        - int'(commit_valid_o && commit_ready_i);
        end
    end

    // Called just after a rising edge, returns on the edge of acceptance
    task automatic send_instr(arch_reg_t rs1, arch_reg_t rs2, arch_reg_t rd, logic we);
        int unsigned waited;
        waited = 0;
        in_valid_i <= 1'b1;
        in_rs1_i   <= rs1;
        in_rs2_i   <= rs2;
        in_rd_i    <= rd;
        in_we_i    <= we;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: instruction was never accepted");
                hung = 1'b1;
            end
        end while (!in_ready_o && !hung);
        in_valid_i <= 1'b0;
    endtask

    task automatic drain_list();
        int unsigned waited;
        waited = 0;
        wb_enable <= 1'b1;
        ready_pct <= 100;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: graduation list did not drain");
                hung = 1'b1;
            end
        end while (inflight != 0 && !hung);
    endtask

    task automatic random_stream(int unsigned count, int unsigned ready);
        wb_enable <= 1'b1;
        ready_pct <= ready;
        for (int unsigned n = 0; n < count && !hung; n++) begin
            send_instr(arch_reg_t'($urandom_range(31)), arch_reg_t'($urandom_range(31)),
                       arch_reg_t'($urandom_range(31)), $urandom_range(3) != 0);
            // Mostly bursts, sometimes a gap
            if ($urandom_range(3) == 0) begin
                repeat ($urandom_range(4, 1)) @(posedge clk_i);
            end
        end
        drain_list();
    endtask

    initial begin
        void'($urandom(32'h53ff));
        hung = 1'b0;
        rstn_i     <= 1'b0;
        in_valid_i <= 1'b0;
        in_rs1_i   <= '0;
        in_rs2_i   <= '0;
        in_rd_i    <= '0;
        in_we_i    <= 1'b0;
        wb_enable  <= 1'b0;
        ready_pct  <= 100;
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        send_instr(arch_reg_t'(3), arch_reg_t'(7), arch_reg_t'(5), 1'b1);
        drain_list();
        scoreboard.report_test("reset state and first rename");

        send_instr(arch_reg_t'(4), arch_reg_t'(5), arch_reg_t'(0), 1'b1);
        send_instr(arch_reg_t'(5), arch_reg_t'(6), arch_reg_t'(9), 1'b0);
        send_instr(arch_reg_t'(9), arch_reg_t'(5), arch_reg_t'(9), 1'b1);
        drain_list();
        scoreboard.report_test("non-allocating instructions");

        // No writeback, so the list fills and nothing retires
        wb_enable <= 1'b0;
        ready_pct <= 0;
        for (int unsigned n = 0; n < `RENAME_GL_DEPTH && !hung; n++) begin
            send_instr(arch_reg_t'(n), arch_reg_t'(n + 1), arch_reg_t'(n + 1), 1'b1);
        end
        repeat (4) @(posedge clk_i);
        wb_enable <= 1'b1;
        ready_pct <= 100;
        send_instr(arch_reg_t'(1), arch_reg_t'(2), arch_reg_t'(3), 1'b1);
        drain_list();
        scoreboard.report_test("full graduation list");

        random_stream(300, 90);
        scoreboard.report_test("random rename stream");
        random_stream(300, 25);
        scoreboard.report_test("out-of-order writeback with commit stalls");
        random_stream(200, 100);
        scoreboard.report_test("free register reuse");

        scoreboard.report_summary();
        if (hung || error_count != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
logic/rename_pkg.sv
logic/free_list.sv
logic/rename_table.sv
logic/graduation_list.sv
logic/rename_unit.sv
test/rename_checker.sv
test/tb_rename_unit.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
TOP       := tb_rename_unit
FILELIST  := sources.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)
